// ==== design/conv_pkg.sv ====
package conv_pkg;

    // Default accumulator width; holds a 256-tap window of full-scale products
    localparam int DEF_ACC_W = 24;

    // Requantization shift applied after bias and ReLU
    localparam int DEF_SHIFT = 8;

    // Unsigned activation from the previous layer
    typedef logic [7:0] act_t;

    // Unsigned weight
    typedef logic [7:0] wgt_t;

    // Approximate product of one tap
    typedef logic [15:0] prod_t;

    // Lane sum and combined two-lane total
    typedef logic [23:0] sum_t;

    // Per-pixel bias
    typedef logic signed [15:0] bias_t;

    // Requantized output pixel
    typedef logic [7:0] pix_t;

endpackage

// ==== design/tap_if.sv ====
`timescale 1ns/1ps

interface tap_if;
    import conv_pkg::*;

    act_t act;   // Activation of the current tap
    wgt_t wgt;   // Weight of the current tap
    logic valid; // One tap per cycle with valid high
    logic first; // First tap of a window
    logic last;  // Final tap of a window

    modport src (
        output act,
        output wgt,
        output valid,
        output first,
        output last
    );

    modport snk (
        input act,
        input wgt,
        input valid,
        input first,
        input last
    );

endinterface

// ==== design/approx_mult_xfyw.sv ====
`timescale 1ns/1ps

module approx_mult_xfyw (
    input  conv_pkg::act_t  x,
    input  conv_pkg::wgt_t  y,
    output conv_pkg::prod_t z
);
    import conv_pkg::*;

    localparam int ROWS  = 8;
    localparam int CMP_W = 13;
    localparam int N_CMP = 6;

    wgt_t             row [ROWS];
    logic [CMP_W-1:0] cmp [N_CMP];
    prod_t            exact_hi;
    prod_t            approx_lo;

    // Row i is the weight gated by activation bit i
    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            row[i] = y & {8{x[i]}};
        end
    end

    // Rows 0 to 5 are compressed and bits 0 to 2 are dropped
    always_comb begin
        for (int k = 0; k < N_CMP; k++) begin
            cmp[k] = '0;
        end

        cmp[0][3]  = row[0][3] ^ row[1][2];
        cmp[0][4]  = row[4][0];
        cmp[0][5]  = row[2][2] & row[3][1];
        cmp[0][6]  = row[0][5] ^ row[1][4];
        cmp[0][7]  = row[0][7] ^ row[1][6];
        cmp[0][8]  = row[1][7];
        cmp[0][9]  = row[2][6] & row[3][5];
        cmp[0][10] = row[3][7];
        cmp[0][11] = row[4][6] & row[5][5];
        cmp[0][12] = row[4][7] & row[5][6];

        cmp[1][6]  = row[4][2] ^ row[5][1];
        cmp[1][7]  = row[2][5] & row[3][4];
        cmp[1][8]  = row[2][5] ^ row[3][4];
        cmp[1][9]  = row[2][7] | row[3][6];
        cmp[1][10] = row[4][6] ^ row[5][5];
        cmp[1][11] = row[4][7] ^ row[5][6];
        cmp[1][12] = row[5][7];

        cmp[2][8]  = row[2][6] | row[3][5];
        cmp[2][9]  = row[4][5] & row[5][4];

        cmp[3][8]  = row[4][3] & row[5][2];
        cmp[3][9]  = row[4][5] | row[5][4];

        cmp[4][8]  = row[4][3] | row[5][2];

        cmp[5][8]  = row[4][4] ^ row[5][3];
    end

    // The two top rows go in at full precision
    always_comb begin
        exact_hi = prod_t'({row[6], 6'b0}) + prod_t'({row[7], 7'b0});
    end

    always_comb begin
        approx_lo = '0;
        for (int k = 0; k < N_CMP; k++) begin
            approx_lo = approx_lo + prod_t'(cmp[k]);
        end
    end

    assign z = exact_hi + approx_lo;

endmodule

// ==== design/mac_lane.sv ====
`timescale 1ns/1ps

module mac_lane #(
    parameter int ACC_W = conv_pkg::DEF_ACC_W
) (
    input  logic           clk,
    input  logic           rst_n,
    tap_if.snk             tap,
    output conv_pkg::sum_t sum,
    output logic           done
);
    import conv_pkg::*;

    prod_t            prod;
    logic [ACC_W-1:0] acc;

    approx_mult_xfyw u_mult (
        .x (tap.act),
        .y (tap.wgt),
        .z (prod)
    );

    // A first tap reloads the accumulator so windows can run back to back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (tap.valid) begin
            if (tap.first) begin
                acc <= ACC_W'(prod);
            end else begin
                acc <= acc + ACC_W'(prod);
            end
        end
    end

    // Done lines up with the cycle in which acc holds the window total
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= tap.valid & tap.last;
        end
    end

    assign sum = sum_t'(acc); // Held until the next valid tap

endmodule

// ==== design/conv_post.sv ====
`timescale 1ns/1ps

module conv_post #(
    parameter int ACC_W = conv_pkg::DEF_ACC_W,
    parameter int SHIFT = conv_pkg::DEF_SHIFT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  conv_pkg::sum_t  sum_a,
    input  logic            done_a,
    input  conv_pkg::sum_t  sum_b,
    input  logic            done_b,
    input  conv_pkg::bias_t bias,
    output conv_pkg::sum_t  total,
    output conv_pkg::pix_t  pix,
    output logic            out_valid
);
    import conv_pkg::*;

    localparam int TOT_W = ACC_W + 1;
    localparam int PRE_W = ACC_W + 2; // Room for the carry and a sign bit

    logic [ACC_W-1:0]        hold_a;
    logic [ACC_W-1:0]        hold_b;
    logic                    held_a;
    logic                    held_b;
    logic                    fire;
    logic [TOT_W-1:0]        tot_full;
    logic signed [PRE_W-1:0] pre_act;
    logic [PRE_W-1:0]        shifted;
    pix_t                    pix_next;

    assign fire = held_a & held_b;

    // Lane sums wait here until the slower lane catches up
    always_ff @(posedge clk) begin
        if (done_a) begin
            hold_a <= ACC_W'(sum_a);
        end
        if (done_b) begin
            hold_b <= ACC_W'(sum_b);
        end
    end

    // A done in the combine cycle starts the next pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_a <= 1'b0;
            held_b <= 1'b0;
        end else begin
            held_a <= done_a | (held_a & ~fire);
            held_b <= done_b | (held_b & ~fire);
        end
    end

    always_comb begin
        tot_full = TOT_W'(hold_a) + TOT_W'(hold_b);
        pre_act  = $signed({1'b0, tot_full}) + PRE_W'(bias);
        shifted  = PRE_W'(pre_act) >> SHIFT;
        if (pre_act[PRE_W-1]) begin
            pix_next = '0; // ReLU
        end else if (shifted > PRE_W'(pix_t'('1))) begin
            pix_next = '1;
        end else begin
            pix_next = pix_t'(shifted);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total     <= '0;
            pix       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
            if (fire) begin
                total <= sum_t'(tot_full[ACC_W-1:0]);
                pix   <= pix_next;
            end
        end
    end

endmodule

// ==== design/conv_dot_top.sv ====
`timescale 1ns/1ps

module conv_dot_top #(
    parameter int ACC_W = conv_pkg::DEF_ACC_W,
    parameter int SHIFT = conv_pkg::DEF_SHIFT
) (
    input  logic            clk,
    input  logic            rst_n,
    input  conv_pkg::act_t  act_a,
    input  conv_pkg::wgt_t  wgt_a,
    input  logic            valid_a,
    input  logic            first_a,
    input  logic            last_a,
    input  conv_pkg::act_t  act_b,
    input  conv_pkg::wgt_t  wgt_b,
    input  logic            valid_b,
    input  logic            first_b,
    input  logic            last_b,
    input  conv_pkg::bias_t bias,
    output conv_pkg::sum_t  total,
    output conv_pkg::pix_t  pix,
    output logic            out_valid
);
    import conv_pkg::*;

    tap_if tap_a ();
    tap_if tap_b ();

    sum_t sum_a;
    sum_t sum_b;
    logic done_a;
    logic done_b;

    assign tap_a.act   = act_a;
    assign tap_a.wgt   = wgt_a;
    assign tap_a.valid = valid_a;
    assign tap_a.first = first_a;
    assign tap_a.last  = last_a;

    assign tap_b.act   = act_b;
    assign tap_b.wgt   = wgt_b;
    assign tap_b.valid = valid_b;
    assign tap_b.first = first_b;
    assign tap_b.last  = last_b;

    mac_lane #(.ACC_W(ACC_W)) u_lane_a (
        .clk   (clk),
        .rst_n (rst_n),
        .tap   (tap_a.snk),
        .sum   (sum_a),
        .done  (done_a)
    );

    mac_lane #(.ACC_W(ACC_W)) u_lane_b (
        .clk   (clk),
        .rst_n (rst_n),
        .tap   (tap_b.snk),
        .sum   (sum_b),
        .done  (done_b)
    );

    conv_post #(
        .ACC_W (ACC_W),
        .SHIFT (SHIFT)
    ) u_post (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_a     (sum_a),
        .done_a    (done_a),
        .sum_b     (sum_b),
        .done_b    (done_b),
        .bias      (bias),
        .total     (total),
        .pix       (pix),
        .out_valid (out_valid)
    );

endmodule

// ==== dv/conv_dot_ref.svh ====
`ifndef CONV_DOT_REF_SVH
`define CONV_DOT_REF_SVH

// Activation bit r gating weight bit c
function automatic int pp_bit(input act_t a, input wgt_t w, input int r, input int c);
    return int'(a[r] & w[c]);
endfunction

function automatic prod_t ref_mult(input act_t a, input wgt_t w);
    int s;
    s = 0;
    for (int c = 0; c < 8; c++) begin
        s += pp_bit(a, w, 6, c) << (6 + c); // Top two rows are kept exact
        s += pp_bit(a, w, 7, c) << (7 + c);
    end
    s += (pp_bit(a, w, 0, 3) ^ pp_bit(a, w, 1, 2)) << 3;
    s += pp_bit(a, w, 4, 0) << 4;
    s += (pp_bit(a, w, 2, 2) & pp_bit(a, w, 3, 1)) << 5;
    s += ((pp_bit(a, w, 0, 5) ^ pp_bit(a, w, 1, 4))
        + (pp_bit(a, w, 4, 2) ^ pp_bit(a, w, 5, 1))) << 6;
    s += ((pp_bit(a, w, 0, 7) ^ pp_bit(a, w, 1, 6))
        + (pp_bit(a, w, 2, 5) & pp_bit(a, w, 3, 4))) << 7;
    s += (pp_bit(a, w, 1, 7)
        + (pp_bit(a, w, 2, 5) ^ pp_bit(a, w, 3, 4))
        + (pp_bit(a, w, 2, 6) | pp_bit(a, w, 3, 5))
        + (pp_bit(a, w, 4, 3) & pp_bit(a, w, 5, 2))
        + (pp_bit(a, w, 4, 3) | pp_bit(a, w, 5, 2))
        + (pp_bit(a, w, 4, 4) ^ pp_bit(a, w, 5, 3))) << 8;
    s += ((pp_bit(a, w, 2, 6) & pp_bit(a, w, 3, 5))
        + (pp_bit(a, w, 2, 7) | pp_bit(a, w, 3, 6))
        + (pp_bit(a, w, 4, 5) & pp_bit(a, w, 5, 4))
        + (pp_bit(a, w, 4, 5) | pp_bit(a, w, 5, 4))) << 9;
    s += (pp_bit(a, w, 3, 7) + (pp_bit(a, w, 4, 6) ^ pp_bit(a, w, 5, 5))) << 10;
    s += ((pp_bit(a, w, 4, 6) & pp_bit(a, w, 5, 5))
        + (pp_bit(a, w, 4, 7) ^ pp_bit(a, w, 5, 6))) << 11;
    s += ((pp_bit(a, w, 4, 7) & pp_bit(a, w, 5, 6)) + pp_bit(a, w, 5, 7)) << 12;
    return prod_t'(s);
endfunction

function automatic sum_t ref_window(input act_t acts [256], input wgt_t wgts [256],
                                    input int n);
    sum_t s;
    s = '0;
    for (int i = 0; i < n; i++) begin
        s += sum_t'(ref_mult(acts[i], wgts[i]));
    end
    return s;
endfunction

// Bias, ReLU, requantizing shift and saturation to one pixel
function automatic pix_t ref_pix(input sum_t total, input bias_t b);
    longint pre;
    longint q;
    pre = longint'(total) + longint'(b);
    if (pre < 0) begin
        return '0;
    end
    q = pre >> DEF_SHIFT;
    return (q > 255) ? pix_t'(255) : pix_t'(q);
endfunction

`endif

// ==== dv/conv_dot_tb.sv ====
`timescale 1ns/1ps

module conv_dot_tb;
    import conv_pkg::*;

    `include "conv_dot_ref.svh"

    localparam int TIMEOUT = 50;
    localparam int SLOTS   = 128;
    localparam int LAT     = 4; // Counter at the drive edge to counter when out_valid is seen

    logic  clk = 1'b0;
    logic  rst_n;
    act_t  act_a;
    wgt_t  wgt_a;
    logic  valid_a;
    logic  first_a;
    logic  last_a;
    act_t  act_b;
    wgt_t  wgt_b;
    logic  valid_b;
    logic  first_b;
    logic  last_b;
    bias_t bias;
    sum_t  total;
    pix_t  pix;
    logic  out_valid;

    logic [18:0] sched [2][SLOTS]; // {valid, first, last, act, wgt} per lane and slot
    act_t        win_act [256];
    wgt_t        win_wgt [256];
    sum_t        exp_total_q [$];
    pix_t        exp_pix_q [$];
    int          exp_slot_q [$];
    int          cyc = 0;
    int          base_cyc = 0;
    int          n_expected = 0;
    int          n_results = 0;
    int          n_errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    conv_dot_top u_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    task automatic check_sum(input string what, input sum_t got, input sum_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            n_errors++;
        end
    endtask

    task automatic check_pix(input string what, input pix_t got, input pix_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            n_errors++;
        end
    endtask

    // Outputs change only on the rising edge
    always @(negedge clk) begin : monitor
        int slot;
        if (rst_n && out_valid) begin
            n_results++;
            if (exp_total_q.size() == 0) begin
                $display("error at %0t ns: out_valid with no result pending", $time);
                n_errors++;
            end else begin
                slot = exp_slot_q.pop_front();
                check_sum("total", total, exp_total_q.pop_front());
                check_pix("pix", pix, exp_pix_q.pop_front());
                if (cyc != base_cyc + slot + LAT) begin
                    $display("mismatch at %0t ns: out_valid in cycle %0d, expected %0d",
                             $time, cyc, base_cyc + slot + LAT);
                    n_errors++;
                end
            end
        end
    end

    task automatic clear_sched();
        for (int l = 0; l < 2; l++) begin
            for (int s = 0; s < SLOTS; s++) begin
                sched[l][s] = '0;
            end
        end
    endtask

    task automatic load_window(input int lane, input int off, input int n, input int gap_at,
                               input bit full, output sum_t exp_sum, output int last_slot);
        int   s;
        act_t a;
        wgt_t w;
        s = off;
        for (int i = 0; i < n; i++) begin
            a = full ? act_t'(255) : act_t'($urandom);
            w = full ? wgt_t'(255) : wgt_t'($urandom);
            win_act[i] = a;
            win_wgt[i] = w;
            sched[lane][s] = {1'b1, i == 0, i == n - 1, a, w};
            s++;
            if (i == gap_at) begin
                repeat (3) begin // Junk taps with valid low
                    sched[lane][s] = {3'b000, act_t'($urandom), wgt_t'($urandom)};
                    s++;
                end
            end
        end
        last_slot = s - 1;
        exp_sum = ref_window(win_act, win_wgt, n);
    endtask

    task automatic expect_result(input sum_t tot, input bias_t b, input int slot);
        exp_total_q.push_back(tot);
        exp_pix_q.push_back(ref_pix(tot, b));
        exp_slot_q.push_back(slot);
        n_expected++;
    endtask

    task automatic play(input int n, input bias_t b);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            if (i == 0) begin
                base_cyc = cyc;
                bias     <= b;
            end
            {valid_a, first_a, last_a, act_a, wgt_a} <= sched[0][i];
            {valid_b, first_b, last_b, act_b, wgt_b} <= sched[1][i];
        end
        @(posedge clk);
        {valid_a, first_a, last_a, act_a, wgt_a} <= '0;
        {valid_b, first_b, last_b, act_b, wgt_b} <= '0;
    endtask

    task automatic wait_results(input string name);
        int waited;
        waited = 0;
        while (n_results < n_expected && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (n_results < n_expected) begin
            $display("%s: no result arrived within %0d cycles", name, TIMEOUT);
            n_errors++;
            exp_total_q.delete();
            exp_pix_q.delete();
            exp_slot_q.delete();
            n_expected = n_results;
        end
        repeat (4) @(posedge clk); // A stray second out_valid would show up here
    endtask

    task automatic report(input string name, input int errs);
        if (n_errors == errs) begin
            n_pass++;
            $display("test %s: passed", name);
        end else begin
            n_fail++;
            $display("test %s: failed with %0d errors", name, n_errors - errs);
        end
    endtask

    task automatic single_pair(input act_t aa, input wgt_t wa, input act_t ab, input wgt_t wb,
                               input sum_t exp, input bias_t b);
        clear_sched();
        sched[0][0] = {3'b111, aa, wa};
        sched[1][0] = {3'b111, ab, wb};
        expect_result(exp, b, 0);
        play(1, b);
        wait_results("single tap pair");
    endtask

    task automatic pair_windows(input int off_a, input int off_b, input int n, input int gap_a,
                                input bit full, input bias_t b);
        sum_t sa;
        sum_t sb;
        int   la;
        int   lb;
        int   last;
        clear_sched();
        load_window(0, off_a, n, gap_a, full, sa, la);
        load_window(1, off_b, n, -1, full, sb, lb);
        last = (la > lb) ? la : lb;
        expect_result(sa + sb, b, last);
        play(last + 1, b);
        wait_results("window pair");
    endtask

    initial begin
        int   errs;
        act_t aa;
        wgt_t wa;
        act_t ab;
        wgt_t wb;
        sum_t rs [4];
        int   rl [4];

        void'($urandom(32'hf23c));
        rst_n = 1'b0;
        bias  = '0;
        {valid_a, first_a, last_a, act_a, wgt_a} = '0;
        {valid_b, first_b, last_b, act_b, wgt_b} = '0;
        clear_sched();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        errs = n_errors;
        repeat (8) begin
            aa = act_t'($urandom);
            wa = wgt_t'($urandom);
            ab = act_t'($urandom);
            wb = wgt_t'($urandom);
            single_pair(aa, wa, ab, wb, sum_t'(ref_mult(aa, wa)) + sum_t'(ref_mult(ab, wb)), '0);
        end
        single_pair('0, wgt_t'($urandom), '0, wgt_t'($urandom), '0, '0);
        wa = wgt_t'($urandom);
        wb = wgt_t'($urandom);
        single_pair(8'hc0, wa, 8'hc0, wb, sum_t'(192 * int'(wa) + 192 * int'(wb)), '0);
        report("single_taps", errs);

        errs = n_errors;
        repeat (4) pair_windows(0, 0, 25, -1, 1'b0, bias_t'(int'($urandom_range(2000)) - 1000));
        report("full_windows", errs);

        errs = n_errors;
        pair_windows(0, 40, 25, -1, 1'b0, '0); // Lane B lags
        pair_windows(30, 0, 25, -1, 1'b0, '0);
        report("uneven_finish", errs);

        errs = n_errors;
        single_pair(8'd10, 8'd10, 8'd10, 8'd10, 2 * sum_t'(ref_mult(8'd10, 8'd10)), -16'sd30000);
        pair_windows(0, 0, 25, -1, 1'b1, '0); // Full-scale taps saturate the pixel
        repeat (8) begin
            aa = act_t'($urandom_range(127));
            wa = wgt_t'($urandom_range(127));
            ab = act_t'($urandom_range(127));
            wb = wgt_t'($urandom_range(127));
            single_pair(aa, wa, ab, wb, sum_t'(ref_mult(aa, wa)) + sum_t'(ref_mult(ab, wb)),
                        bias_t'(int'($urandom_range(4000)) - 2000));
        end
        report("pixel_path", errs);

        errs = n_errors;
        clear_sched();
        load_window(0, 0, 10, -1, 1'b0, rs[0], rl[0]);
        load_window(1, 0, 10, -1, 1'b0, rs[1], rl[1]);
        load_window(0, 10, 10, -1, 1'b0, rs[2], rl[2]);
        load_window(1, 10, 10, -1, 1'b0, rs[3], rl[3]);
        expect_result(rs[0] + rs[1], '0, rl[1]);
        expect_result(rs[2] + rs[3], '0, rl[3]);
        play(20, '0);
        wait_results("back-to-back windows");
        pair_windows(0, 0, 25, 5, 1'b0, '0); // Lane A idles three cycles mid-window
        report("restart", errs);

        $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, n_errors);
        if (n_fail == 0 && n_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== conv_dot.f ====
+incdir+dv
design/conv_pkg.sv
design/tap_if.sv
design/approx_mult_xfyw.sv
design/mac_lane.sv
design/conv_post.sv
design/conv_dot_top.sv
dv/conv_dot_tb.sv
